// File: design/decimPkg.sv
package decimPkg;

    localparam int TAPS = 16;                       // filter taps.
    localparam int GROUP = 4;                       // taps summed per group.
    localparam int COEF_W = 12;
    localparam int ACC_W = COEF_W + $clog2(TAPS);   // worst case sum of all taps.
    localparam int OUT_W = 14;

    typedef logic signed [COEF_W-1:0] coefT;
    typedef logic signed [ACC_W-1:0] accT;
    typedef logic [OUT_W-1:0] outWordT;             // offset binary.
    typedef logic [4:0] cfgAddrT;
    typedef logic [15:0] cfgDataT;
    typedef logic [3:0] decimT;                     // 1 to 15.
    typedef logic [1:0] shiftT;

    // addresses 0 to TAPS-1 hold the coefficients
    localparam cfgAddrT ADDR_DECIM = 5'd16;
    localparam cfgAddrT ADDR_SHIFT = 5'd17;

    typedef struct packed {
        logic    strobe;
        cfgAddrT addr;
        cfgDataT data;
    } cfgWriteS;

    typedef struct packed {
        logic strobe;
        logic bitVal;                               // 1 is +1, 0 is -1.
    } sampleInS;

endpackage

// File: design/coefRegs.sv
module coefRegs #(
    parameter int TAPS = decimPkg::TAPS,
    parameter int COEF_W = decimPkg::COEF_W
) (
    input  logic                       clkDS,
    input  logic                       arstN,
    input  decimPkg::cfgWriteS         cfg,
    output decimPkg::coefT [TAPS-1:0]  coefs,
    output decimPkg::decimT            decim,
    output decimPkg::shiftT            shift
);

    localparam int DECIM_W = $bits(decimPkg::decimT);
    localparam int SHIFT_W = $bits(decimPkg::shiftT);

    decimPkg::decimT decimWr;

    // a ratio of 0 would never evaluate, so it is taken as 1
    assign decimWr = (cfg.data[DECIM_W-1:0] == '0) ? decimPkg::decimT'(1)
                                                   : cfg.data[DECIM_W-1:0];

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            coefs <= '0;
            decim <= decimPkg::decimT'(1);
            shift <= '0;
        end else if (cfg.strobe) begin
            if (cfg.addr < TAPS) begin
                coefs[cfg.addr] <= decimPkg::coefT'(signed'(cfg.data[COEF_W-1:0]));
            end else if (cfg.addr == decimPkg::ADDR_DECIM) begin
                decim <= decimWr;
            end else if (cfg.addr == decimPkg::ADDR_SHIFT) begin
                shift <= cfg.data[SHIFT_W-1:0];
            end
            // anything else is dropped.
        end
    end

endmodule

// File: design/bitHistory.sv
module bitHistory #(
    parameter int TAPS = decimPkg::TAPS
) (
    input  logic                clkDS,
    input  logic                arstN,
    input  decimPkg::sampleInS  sampleIn,
    input  decimPkg::decimT     decim,
    output logic [TAPS-1:0]     taps,
    output logic                evalStrobe
);

    decimPkg::decimT sampleCnt;
    logic lastOfBlock;

    // >= keeps the counter from running past a ratio lowered mid-stream
    assign lastOfBlock = (sampleCnt >= decimPkg::decimT'(decim - 1'b1));

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            taps       <= '0;              // all taps read as -1.
            sampleCnt  <= '0;
            evalStrobe <= 1'b0;
        end else begin
            evalStrobe <= 1'b0;
            if (sampleIn.strobe) begin
                taps <= {taps[TAPS-2:0], sampleIn.bitVal};   // newest at bit 0.
                if (lastOfBlock) begin
                    sampleCnt  <= '0;
                    evalStrobe <= 1'b1;    // lines up with the history holding this bit.
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/tapGroupSum.sv
module tapGroupSum #(
    parameter int TAPS = decimPkg::TAPS,
    parameter int GROUP = decimPkg::GROUP
) (
    input  logic                              clkDS,
    input  logic                              arstN,
    input  logic [TAPS-1:0]                   taps,
    input  logic                              evalStrobe,
    input  decimPkg::coefT [TAPS-1:0]         coefs,
    output decimPkg::accT [TAPS/GROUP-1:0]    groupSums,
    output logic                              groupValid
);

    localparam int NUM_GROUPS = TAPS / GROUP;

    decimPkg::accT [NUM_GROUPS-1:0] groupComb;

    // select-and-add over the taps of each group
    always_comb begin
        decimPkg::accT term;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            groupComb[g] = '0;
            for (int k = 0; k < GROUP; k++) begin
                term = decimPkg::accT'(signed'(coefs[g*GROUP+k]));
                if (taps[g*GROUP+k]) begin
                    groupComb[g] = groupComb[g] + term;
                end else begin
                    groupComb[g] = groupComb[g] - term;
                end
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (evalStrobe) begin
            groupSums <= groupComb;    // held until the next evaluation.
        end
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            groupValid <= 1'b0;
        end else begin
            groupValid <= evalStrobe;
        end
    end

endmodule

// File: design/adderTree.sv
module adderTree #(
    parameter int NUM_IN = decimPkg::TAPS / decimPkg::GROUP
) (
    input  logic                          clkDS,
    input  logic                          arstN,
    input  decimPkg::accT [NUM_IN-1:0]    groupSums,
    input  logic                          groupValid,
    output decimPkg::accT                 total,
    output logic                          totalValid
);

    // one register stage per level, a single input still gets one stage
    localparam int LEVELS = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

    logic [LEVELS-1:0] validPipe;

    generate
        if (NUM_IN == 1) begin : g_single
            always_ff @(posedge clkDS) begin
                total <= groupSums[0];
            end
        end else begin : g_tree
            // heap order, node 1 is the root and node i adds nodes 2i and 2i+1
            decimPkg::accT node [1:NUM_IN-1];

            for (genvar i = 1; i < NUM_IN; i++) begin : g_node
                if (2*i >= NUM_IN) begin : g_leaf
                    always_ff @(posedge clkDS) begin
                        node[i] <= groupSums[2*i-NUM_IN] + groupSums[2*i+1-NUM_IN];
                    end
                end else begin : g_inner
                    always_ff @(posedge clkDS) begin
                        node[i] <= node[2*i] + node[2*i+1];
                    end
                end
            end

            assign total = node[1];
        end
    endgenerate

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= LEVELS'({validPipe, groupValid});   // same depth as the tree.
        end
    end

    assign totalValid = validPipe[LEVELS-1];

endmodule

// File: design/outputScaler.sv
module outputScaler #(
    parameter int OUT_W = decimPkg::OUT_W
) (
    input  logic               clkDS,
    input  logic               arstN,
    input  decimPkg::accT      total,
    input  logic               totalValid,
    input  decimPkg::shiftT    shift,
    output decimPkg::outWordT  sampleOut,
    output logic               sampleValid
);

    localparam decimPkg::accT MAX_POS = decimPkg::accT'((1 <<< (OUT_W-1)) - 1);
    localparam decimPkg::accT MAX_NEG = decimPkg::accT'(-(1 <<< (OUT_W-1)));

    decimPkg::accT shifted;
    logic signed [OUT_W-1:0] satVal;

    assign shifted = total >>> shift;

    always_comb begin
        if (shifted > MAX_POS) begin
            satVal = MAX_POS[OUT_W-1:0];
        end else if (shifted < MAX_NEG) begin
            satVal = MAX_NEG[OUT_W-1:0];
        end else begin
            satVal = shifted[OUT_W-1:0];
        end
    end

    always_ff @(posedge clkDS) begin
        if (totalValid) begin
            sampleOut <= decimPkg::outWordT'({~satVal[OUT_W-1], satVal[OUT_W-2:0]});  // to offset binary.
        end
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= totalValid;
        end
    end

endmodule

// File: design/decimTop.sv
module decimTop #(
    parameter int TAPS = decimPkg::TAPS,
    parameter int GROUP = decimPkg::GROUP,
    parameter int COEF_W = decimPkg::COEF_W,
    parameter int OUT_W = decimPkg::OUT_W
) (
    input  logic                clkDS,
    input  logic                arstN,
    input  decimPkg::cfgWriteS  cfg,
    input  decimPkg::sampleInS  sampleIn,
    output decimPkg::outWordT   sampleOut,
    output logic                sampleValid
);

    localparam int NUM_GROUPS = TAPS / GROUP;

    decimPkg::coefT [TAPS-1:0] coefs;
    decimPkg::decimT decim;
    decimPkg::shiftT shift;

    logic [TAPS-1:0] taps;
    logic evalStrobe;
    decimPkg::accT [NUM_GROUPS-1:0] groupSums;
    logic groupValid;
    decimPkg::accT total;
    logic totalValid;

    coefRegs #(
        .TAPS   (TAPS),
        .COEF_W (COEF_W)
    ) u_coefRegs (
        .clkDS (clkDS),
        .arstN (arstN),
        .cfg   (cfg),
        .coefs (coefs),
        .decim (decim),
        .shift (shift)
    );

    bitHistory #(.TAPS(TAPS)) u_bitHistory (
        .clkDS      (clkDS),
        .arstN      (arstN),
        .sampleIn   (sampleIn),
        .decim      (decim),
        .taps       (taps),
        .evalStrobe (evalStrobe)
    );

    tapGroupSum #(
        .TAPS  (TAPS),
        .GROUP (GROUP)
    ) u_tapGroupSum (
        .clkDS      (clkDS),
        .arstN      (arstN),
        .taps       (taps),
        .evalStrobe (evalStrobe),
        .coefs      (coefs),
        .groupSums  (groupSums),
        .groupValid (groupValid)
    );

    adderTree #(.NUM_IN(NUM_GROUPS)) u_adderTree (
        .clkDS      (clkDS),
        .arstN      (arstN),
        .groupSums  (groupSums),
        .groupValid (groupValid),
        .total      (total),
        .totalValid (totalValid)
    );

    outputScaler #(.OUT_W(OUT_W)) u_outputScaler (
        .clkDS       (clkDS),
        .arstN       (arstN),
        .total       (total),
        .totalValid  (totalValid),
        .shift       (shift),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid)
    );

endmodule

// File: tests/decimTb.sv
module decimTb;

    localparam int TIMEOUT = 100;       // cycles allowed for any wait.
    localparam int SETTLE = 6;          // pipeline depth plus one.

    logic clkDS = 1'b0;
    logic arstN;
    decimPkg::cfgWriteS cfg;
    decimPkg::sampleInS sampleIn;
    decimPkg::outWordT sampleOut;
    logic sampleValid;

    decimPkg::outWordT gotQ[$];
    decimPkg::outWordT expQ[$];
    string testName = "";
    int expCount;
    int testErrors;
    int passCount;
    int failCount;
    int errCount;                       // problems outside any test.

    decimTop u_decimTop (
        .clkDS       (clkDS),
        .arstN       (arstN),
        .cfg         (cfg),
        .sampleIn    (sampleIn),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid)
    );

    always #4 clkDS = ~clkDS;

    // outputs are taken at the edge, before the DUT updates them
    always @(posedge clkDS) begin
        if (arstN && sampleValid) begin
            gotQ.push_back(sampleOut);
        end
    end

    // sampleValid has to read a clean low all through reset.
    always @(negedge clkDS) begin
        if (!arstN && sampleValid !== 1'b0) begin
            $display("sampleValid was not low during reset in test %s", testName);
            testErrors++;
        end
    end

    task automatic nextCycle();
        @(posedge clkDS);
        #1;                             // inputs change just after the edge.
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        cfg = '0;
        sampleIn = '0;
        for (int i = 0; i < 10; i++) begin
            nextCycle();
        end
        arstN = 1'b1;
    endtask

    task automatic writeCfg(input decimPkg::cfgAddrT addr, input decimPkg::cfgDataT data);
        cfg = '{strobe: 1'b1, addr: addr, data: data};
        nextCycle();
        cfg = '0;
    endtask

    task automatic strobeBit(input logic bitVal);
        sampleIn = '{strobe: 1'b1, bitVal: bitVal};
        nextCycle();
        sampleIn = '0;
    endtask

    task automatic checkOut(input decimPkg::outWordT expVal, input decimPkg::outWordT actVal);
        if (actVal !== expVal) begin
            $display("Fail %s expected %h actual %h", testName, expVal, actVal);
            testErrors++;
        end
    endtask

    task automatic checkCount(input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("Fail %s output count expected %0d actual %0d", testName, expVal, actVal);
            testErrors++;
        end
    endtask

    task automatic drainOutputs();
        int waited;
        waited = 0;
        while (gotQ.size() < expCount && waited < TIMEOUT) begin
            nextCycle();
            waited++;
        end
        if (gotQ.size() < expCount) begin
            $display("Timed out in test %s waiting for the outputs", testName);
            testErrors++;
        end
        for (int i = 0; i < SETTLE; i++) begin
            nextCycle();                // extra outputs would show up here.
        end
    endtask

    task automatic finishTest();
        drainOutputs();
        checkCount(expCount, gotQ.size());
        foreach (expQ[i]) begin
            if (i < gotQ.size()) begin
                checkOut(expQ[i], gotQ[i]);
            end
        end
        if (testErrors == 0) begin
            $display("Pass %s with %0d outputs", testName, gotQ.size());
            passCount++;
        end else begin
            $display("Test %s finished with %0d errors", testName, testErrors);
            failCount++;
        end
    endtask

    initial begin
        int fd;
        int n;
        int rep;
        string line;
        string tag;
        string bits;
        logic [15:0] v1;
        logic [15:0] v2;
        passCount = 0;
        failCount = 0;
        errCount = 0;
        testErrors = 0;
        expCount = 0;
        arstN = 1'b0;
        cfg = '0;
        sampleIn = '0;
        fd = $fopen("tests/decimStimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errCount++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            tag = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", tag);
            if (n < 1 || tag == "#") begin
                continue;
            end
            case (tag)
                "T": begin
                    n = $sscanf(line, "%s %s", tag, testName);
                    testErrors = 0;
                    expCount = 0;
                    expQ.delete();
                    applyReset();
                    gotQ.delete();
                end
                "W": begin
                    n = $sscanf(line, "%s %h %h %d", tag, v1, v2, rep);
                    if (n < 4) begin
                        rep = 1;
                    end
                    for (int i = 0; i < rep; i++) begin
                        writeCfg(decimPkg::cfgAddrT'(v1 + i), v2);
                    end
                end
                "S": begin
                    n = $sscanf(line, "%s %s", tag, bits);
                    for (int i = 0; i < bits.len(); i++) begin
                        strobeBit(bits[i] == "1");
                    end
                end
                "I": begin
                    n = $sscanf(line, "%s %d", tag, rep);
                    for (int i = 0; i < rep; i++) begin
                        nextCycle();
                    end
                end
                "E": begin
                    n = $sscanf(line, "%s %h %d", tag, v1, rep);
                    if (n < 3) begin
                        rep = 1;
                    end
                    for (int i = 0; i < rep; i++) begin
                        expQ.push_back(decimPkg::outWordT'(v1));
                    end
                end
                "C": n = $sscanf(line, "%s %d", tag, expCount);
                "D": finishTest();
                default: begin
                    $display("Unknown record %s in the stimulus file", tag);
                    errCount++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && errCount == 0 && passCount > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tests/decimStimulus.txt
# T name | W addr data [count] | S bits | I cycles | E value [count] | C outputs | D
# addr, data and outputs in hex, bits are strobed on back to back cycles
T resetZero
S 1010011100101101
E 2000 16
C 16
D
T impulseTap5
W 05 0064
S 1011001110
E 1F9C 5
E 2064
E 1F9C
E 2064 2
E 1F9C
C 10
D
T decimBy4
W 10 0004
W 00 0050
W 03 0020
S 11000
I 3
S 11010
I 5
S 111000
E 1FD0
E 1F90
E 2070
E 1FD0
C 4
D
T mixedShift2
W 00 012C
W 01 FF38
W 02 0096
W 03 FF9C
W 04 004B
W 05 FFCE
W 06 0190
W 07 FEA2
W 08 00DC
W 09 FF4C
W 0A 005A
W 0B FFC4
W 0C 01F4
W 0D FFE7
W 0E 000A
W 0F FFFB
W 11 0002
S 1101111
E 1FD4
E 1F70
E 1F25
E 1FED
E 1F63
E 1FC7
E 2038
C 7
D
T saturation
W 00 07FF 16
S 0000
S 1111111111111111
E 0000 9
E 0004
E 1002
E 2000
E 2FFE
E 3FFC
E 3FFF 6
C 20
D
T backToBack
W 00 03E8
W 01 FED4
S 100110
E 2514
E 1AEC
E 1D44
E 2514
E 22BC
E 1AEC
C 6
D

// File: tb.f
design/decimPkg.sv
design/coefRegs.sv
design/bitHistory.sv
design/tapGroupSum.sv
design/adderTree.sv
design/outputScaler.sv
design/decimTop.sv
tests/decimTb.sv
